// ==== hdl/miniCfg.svh ====
`ifndef MINI_CFG_SVH
`define MINI_CFG_SVH

// Depth of the shared word memory
`define MEM_WORDS 256

// Word address width into the memory
`define MEM_AW 8

// Byte address of the run/halt control register on APB
`define CTRL_ADDR 32'h0000_1000

`endif

// ==== hdl/miniPkg.sv ====
package miniPkg;

    // Data or address word
    typedef logic [31:0] word_t;

    // Register number, R0 reads as zero
    typedef logic [3:0] regIdx_t;

    // Opcodes, MiniSRC numbering with the unused codes left out
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opBr   = 5'b10011,
        opNop  = 5'b11010,
        opHlt  = 5'b11011
    } opcode_t;

    // Branch condition in bits 20..19, tested on ra
    typedef enum logic [1:0] {
        brZero    = 2'b00,
        brNonZero = 2'b01,
        brPos     = 2'b10,  // strictly greater than zero
        brNeg     = 2'b11
    } brCond_t;

    // ALU function
    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluAnd = 2'b10,
        aluOr  = 2'b11
    } aluOp_t;

    // Instruction steps
    typedef enum logic [2:0] {
        stepFetch, stepDecode, stepExecute, stepMemory, stepWriteBack, stepHalted
    } step_t;

endpackage

// ==== hdl/controlUnit.sv ====
module controlUnit (
    input  logic             iClk,
    input  logic             nRst,
    input  logic             run,
    // Memory handshake, fields held until memAck
    output logic             memReq,
    output logic             memWe,
    input  logic             memAck,
    input  miniPkg::word_t   memRData,
    output logic             halted,
    // Flags of ra
    input  logic             isZero,
    input  logic             isNeg,
    // PC, IR and address select
    output logic             pcEn,
    output logic             pcBranch,
    output logic             irLoad,
    output logic             maSel,
    // Register file and ALU
    output logic             rfWrite,
    output miniPkg::regIdx_t rfAddrA,
    output miniPkg::regIdx_t rfAddrB,
    output miniPkg::regIdx_t rfAddrW,
    output miniPkg::aluOp_t  aluOp,
    output logic             immSel,
    output logic             wbMemSel,
    output miniPkg::word_t   imm
);
    import miniPkg::*;

    step_t   step;
    word_t   ir;
    opcode_t opcode;
    brCond_t cond;
    logic    isAluReg;
    logic    isAluImm;
    logic    isLd;
    logic    isSt;
    logic    isBr;
    logic    isHlt;
    logic    isMemOp;
    logic    brTaken;

    // Step counter, every instruction walks all five steps
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            step <= stepHalted;
        end else if (run) begin
            step <= stepFetch;
        end else begin
            case (step)
                // Wait for the instruction word
                stepFetch:     step <= memAck ? stepDecode : stepFetch;
                stepDecode:    step <= stepExecute;
                stepExecute:   step <= isHlt ? stepHalted : stepMemory;
                // Only loads and stores wait here
                stepMemory:    step <= (!isMemOp || memAck) ? stepWriteBack : stepMemory;
                stepWriteBack: step <= stepFetch;
                default:       step <= stepHalted;
            endcase
        end
    end

    // Instruction register, idles on a NOP
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            ir <= {opNop, 27'd0};
        end else if (irLoad) begin
            ir <= memRData;
        end
    end

    // Halt status, cleared by a new run
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            halted <= 1'b0;
        end else if (run) begin
            halted <= 1'b0;
        end else if (step == stepExecute && isHlt) begin
            halted <= 1'b1;
        end
    end

    // Field split
    assign opcode = opcode_t'(ir[31:27]);
    assign cond   = brCond_t'(ir[20:19]);
    assign imm    = {{13{ir[18]}}, ir[18:0]};

    // Instruction classes; unknown codes act as NOP
    assign isAluReg = opcode inside {opAdd, opSub, opAnd, opOr};
    assign isAluImm = opcode inside {opAddi, opAndi, opOri};
    assign isLd     = (opcode == opLd);
    assign isSt     = (opcode == opSt);
    assign isBr     = (opcode == opBr);
    assign isHlt    = (opcode == opHlt);
    assign isMemOp  = isLd || isSt;

    // Branch condition against the flags of ra
    always_comb begin
        brTaken = 1'b0;
        case (cond)
            brZero:    brTaken = isZero;
            brNonZero: brTaken = !isZero;
            brPos:     brTaken = !isZero && !isNeg;
            brNeg:     brTaken = isNeg;
        endcase
    end

    // ALU function, address math uses add
    always_comb begin
        case (opcode)
            opSub:         aluOp = aluSub;
            opAnd, opAndi: aluOp = aluAnd;
            opOr, opOri:   aluOp = aluOr;
            default:       aluOp = aluAdd;
        endcase
    end

    // Memory port
    assign memReq = (step == stepFetch) || (step == stepMemory && isMemOp);
    assign memWe  = (step == stepMemory) && isSt;
    // Effective address steered to MAR from execute on
    assign maSel  = isMemOp && (step == stepExecute || step == stepMemory);

    // PC moves on the fetch ack, or jumps in execute
    assign irLoad   = (step == stepFetch) && memAck;
    assign pcBranch = (step == stepExecute) && isBr && brTaken;
    assign pcEn     = irLoad || pcBranch;

    // Register file: A is rb (ra for branches), B is rc (ra for stores)
    assign rfAddrA  = isBr ? ir[26:23] : ir[22:19];
    assign rfAddrB  = isSt ? ir[26:23] : ir[18:15];
    assign rfAddrW  = ir[26:23];
    assign rfWrite  = (step == stepWriteBack) && (isAluReg || isAluImm || isLd);
    assign immSel   = isAluImm || isMemOp;
    assign wbMemSel = isLd;

    // A store stays on the bus until its ack
    assert property (@(posedge iClk) disable iff (!nRst)
        memWe && !memAck && !run |=> memWe && memReq);

    // Load write-back only right after the data came back
    assert property (@(posedge iClk) disable iff (!nRst)
        rfWrite && isLd |-> $past(memAck));

endmodule

// ==== hdl/dataPath.sv ====
module dataPath (
    input  logic             iClk,
    input  logic             nRst,
    input  logic             run,
    // PC and address control
    input  logic             pcEn,
    input  logic             pcBranch,
    input  logic             irLoad,
    input  logic             maSel,
    // Register file and ALU control
    input  logic             rfWrite,
    input  miniPkg::regIdx_t rfAddrA,
    input  miniPkg::regIdx_t rfAddrB,
    input  miniPkg::regIdx_t rfAddrW,
    input  miniPkg::aluOp_t  aluOp,
    input  logic             immSel,
    input  logic             wbMemSel,
    input  miniPkg::word_t   imm,
    // Memory port
    input  logic             memReq,
    input  logic             memAck,
    input  miniPkg::word_t   memRData,
    output miniPkg::word_t   memAddr,
    output miniPkg::word_t   memWData,
    // Flags of the A register
    output logic             isZero,
    output logic             isNeg
);
    import miniPkg::*;

    word_t pc;
    word_t mar;
    word_t mdr;
    word_t aReg;
    word_t bReg;
    word_t zReg;
    word_t rdReg;
    word_t aluB;
    word_t aluY;
    word_t wbData;
    word_t rf [16];

    // PC in words, fetch steps by one, branch adds imm to the stepped PC
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            pc <= '0;
        end else if (run) begin
            pc <= '0;
        end else if (pcEn) begin
            pc <= pcBranch ? pc + imm : pc + 32'd1;
        end
    end

    // Register file, cleared on run so each program starts clean
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            for (int i = 0; i < 16; i++) begin
                rf[i] <= '0;
            end
        end else if (run) begin
            for (int i = 0; i < 16; i++) begin
                rf[i] <= '0;
            end
        end else if (rfWrite && rfAddrW != '0) begin
            rf[rfAddrW] <= wbData;
        end
    end

    // Operand, result and memory data registers
    always_ff @(posedge iClk) begin
        aReg <= rf[rfAddrA];
        bReg <= rf[rfAddrB];
        zReg <= aluY;
        mdr  <= bReg;
        // Load data only, instruction words go to the IR
        if (memAck && !irLoad) begin
            rdReg <= memRData;
        end
    end

    // Four-function ALU
    assign aluB = immSel ? imm : bReg;
    always_comb begin
        case (aluOp)
            aluAdd:  aluY = aReg + aluB;
            aluSub:  aluY = aReg - aluB;
            aluAnd:  aluY = aReg & aluB;
            default: aluY = aReg | aluB;
        endcase
    end

    // MAR follows PC, or the effective address for LD and ST
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            mar <= '0;
        end else begin
            mar <= run ? '0 : (maSel ? aluY : pc);
        end
    end

    assign wbData   = wbMemSel ? rdReg : zReg;
    assign memAddr  = mar;
    assign memWData = mdr;
    assign isZero   = (aReg == '0);
    assign isNeg    = aReg[31];

    // Address held steady across a stalled request
    assert property (@(posedge iClk) disable iff (!nRst)
        memReq && !memAck && !run |=> $stable(memAddr));

endmodule

// ==== hdl/busArbiter.sv ====
`include "miniCfg.svh"

module busArbiter (
    input  logic               iClk,
    input  logic               nRst,
    // APB host port
    input  miniPkg::word_t     paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  miniPkg::word_t     pwdata,
    output miniPkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr,
    // Processor port
    input  logic               memReq,
    input  logic               memWe,
    input  miniPkg::word_t     memAddr,
    input  miniPkg::word_t     memWData,
    output miniPkg::word_t     memRData,
    output logic               memAck,
    output logic               run,
    input  logic               halted,
    // Memory side
    output logic [`MEM_AW-1:0] ramAddr,
    output miniPkg::word_t     ramWData,
    output logic               ramWe,
    input  miniPkg::word_t     ramRData
);
    import miniPkg::*;

    logic  apbIsMem;
    logic  apbIsCtrl;
    logic  apbReq;
    logic  procReq;
    logic  grantApb;
    logic  grantProc;
    logic  procWait;
    logic  s1Apb;
    logic  s1Proc;
    logic  s1Mem;
    logic  s1Ctrl;
    logic  s2Apb;
    logic  s2Proc;
    logic  s2Mem;
    logic  s2Ctrl;
    word_t ctrlRData;

    // APB address decode, anything else is an error
    assign apbIsMem  = paddr < 32'(`MEM_WORDS * 4);
    assign apbIsCtrl = (paddr == `CTRL_ADDR);

    // New requests only, not ones already in the pipe
    assign apbReq  = psel && penable && !s1Apb && !s2Apb;
    assign procReq = memReq && !s1Proc && !s2Proc;
    // APB first, except a processor request that already lost once
    assign grantProc = procReq && (procWait || !apbReq);
    assign grantApb  = apbReq && !grantProc;

    // Grant stage, then data stage one cycle after the RAM address
    always_ff @(posedge iClk or negedge nRst) begin
        if (!nRst) begin
            procWait <= 1'b0;
            s1Apb    <= 1'b0;
            s1Proc   <= 1'b0;
            s1Mem    <= 1'b0;
            s1Ctrl   <= 1'b0;
            s2Apb    <= 1'b0;
            s2Proc   <= 1'b0;
            s2Mem    <= 1'b0;
            s2Ctrl   <= 1'b0;
            ramWe    <= 1'b0;
            run      <= 1'b0;
        end else begin
            procWait <= procReq && !grantProc;
            s1Apb    <= grantApb;
            s1Proc   <= grantProc;
            s1Mem    <= grantApb && apbIsMem;
            s1Ctrl   <= grantApb && apbIsCtrl;
            s2Apb    <= s1Apb;
            s2Proc   <= s1Proc;
            s2Mem    <= s1Mem;
            s2Ctrl   <= s1Ctrl;
            ramWe    <= (grantApb && pwrite && apbIsMem) || (grantProc && memWe);
            // One-cycle restart pulse on a write of bit 0
            run      <= grantApb && pwrite && apbIsCtrl && pwdata[0];
        end
    end

    // Address and write data of the granted port
    always_ff @(posedge iClk) begin
        if (grantApb) begin
            ramAddr  <= paddr[`MEM_AW+1:2];
            ramWData <= pwdata;
        end else if (grantProc) begin
            ramAddr  <= memAddr[`MEM_AW-1:0];
            ramWData <= memWData;
        end
    end

    // Run bit reads back as 0, halted in bit 1
    assign ctrlRData = {30'd0, halted, 1'b0};

    assign pready   = s2Apb;
    assign pslverr  = s2Apb && !s2Mem && !s2Ctrl;
    assign prdata   = s2Mem ? ramRData : (s2Ctrl ? ctrlRData : '0);
    assign memAck   = s2Proc;
    assign memRData = ramRData;

    // Processor request that lost to APB wins the next cycle
    assert property (@(posedge iClk) disable iff (!nRst)
        procReq && !grantProc |=> grantProc);

endmodule

// ==== hdl/sharedMem.sv ====
`include "miniCfg.svh"

module sharedMem (
    input  logic               iClk,
    input  logic [`MEM_AW-1:0] addr,
    input  logic               we,
    input  miniPkg::word_t     wData,
    output miniPkg::word_t     rData
);
    import miniPkg::*;

    // Program and data words
    word_t mem [`MEM_WORDS];

    // Read data one cycle after the address, old word on a write
    always_ff @(posedge iClk) begin
        if (we) begin
            mem[addr] <= wData;
        end
        rData <= mem[addr];
    end

endmodule

// ==== hdl/miniCpuTop.sv ====
`include "miniCfg.svh"

module miniCpuTop (
    input  logic           iClk,
    input  logic           nRst,
    // APB host port
    input  miniPkg::word_t paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  miniPkg::word_t pwdata,
    output miniPkg::word_t prdata,
    output logic           pready,
    output logic           pslverr
);
    import miniPkg::*;

    // Processor memory port and run/halt
    logic    memReq, memWe, memAck, run, halted;
    word_t   memAddr, memWData, memRData;
    // Control unit to datapath
    logic    pcEn, pcBranch, irLoad, maSel, rfWrite, immSel, wbMemSel, isZero, isNeg;
    regIdx_t rfAddrA, rfAddrB, rfAddrW;
    aluOp_t  aluOp;
    word_t   imm;
    // Arbiter to memory
    logic [`MEM_AW-1:0] ramAddr;
    logic    ramWe;
    word_t   ramWData, ramRData;

    controlUnit uCtrl (.*);

    dataPath uData (.*);

    busArbiter uArb (.*);

    sharedMem uMem (
        .iClk  (iClk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wData (ramWData),
        .rData (ramRData)
    );

endmodule

// ==== sim/miniCpuTb.sv ====
`include "miniCfg.svh"

module miniCpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    import miniPkg::*;

    // Four plain random programs plus one run under host traffic
    localparam int NUM_PROGS = 5;
    // Execution budget plus APB loading and readback traffic
    localparam int MAX_CYCLES = NUM_PROGS * 60 * 12 + NUM_PROGS * 1000 * 6 + 6000;

    logic  iClk;
    logic  nRst;
    word_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t pwdata;
    word_t prdata;
    logic  pready;
    logic  pslverr;

    // Reference model state
    word_t modelMem [`MEM_WORDS];
    word_t modelReg [16];
    // Shadow of host writes for the round trip
    word_t shadow [`MEM_WORDS];
    logic  written [`MEM_WORDS];

    int          cycles;
    int          errCount;
    int          testsPassed;
    int          testsFailed;

    miniCpuTop dut (
        .iClk    (iClk),
        .nRst    (nRst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // 4 ns clock
    initial begin
        iClk = 1'b0;
        forever #2 iClk = ~iClk;
    end

    // Cycle budget over the whole run
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge iClk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the processor never halted", cycles);
        $display("test failed");
        $finish;
    end

    // One APB transfer, setup then access held until pready
    task automatic apbXfer(input word_t addr, input logic isWrite, input word_t wdata,
                           output word_t rdata, output logic err);
        @(posedge iClk);
        #1;
        paddr   = addr;
        pwrite  = isWrite;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge iClk);
        #1;
        penable = 1'b1;
        // pready is registered, look at it mid-cycle
        @(negedge iClk);
        while (!pready) begin
            @(negedge iClk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge iClk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reportMismatch(input string name, input word_t expected, input word_t actual);
        $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        errCount++;
    endtask

    task automatic memWrite(input int idx, input word_t data);
        word_t rd;
        logic  err;
        apbXfer(word_t'(idx * 4), 1'b1, data, rd, err);
        if (err) begin
            $display("Unexpected pslverr on a write to word %0d at %0t", idx, $time);
            errCount++;
        end
    endtask

    task automatic memRead(input int idx, output word_t data);
        logic err;
        apbXfer(word_t'(idx * 4), 1'b0, '0, data, err);
        if (err) begin
            $display("Unexpected pslverr on a read of word %0d at %0t", idx, $time);
            errCount++;
        end
    endtask

    task automatic ctrlWrite(input word_t data);
        word_t rd;
        logic  err;
        apbXfer(`CTRL_ADDR, 1'b1, data, rd, err);
        if (err) begin
            $display("Unexpected pslverr on a control register write at %0t", $time);
            errCount++;
        end
    endtask

    task automatic ctrlRead(output word_t data);
        logic err;
        apbXfer(`CTRL_ADDR, 1'b0, '0, data, err);
        if (err) begin
            $display("Unexpected pslverr on a control register read at %0t", $time);
            errCount++;
        end
    endtask

    // Poll bit 1 until the processor reports HLT
    task automatic waitHalted(output word_t status);
        status = '0;
        while (!status[1]) begin
            ctrlRead(status);
        end
    endtask

    task automatic logResult(input string name, input int errBefore);
        if (errCount == errBefore) begin
            testsPassed++;
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, errCount - errBefore);
        end
    endtask

    // Instruction encodings, fields per the ISA layout
    function automatic word_t encReg(opcode_t op, regIdx_t ra, regIdx_t rb, regIdx_t rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic word_t encImm(opcode_t op, regIdx_t ra, regIdx_t rb, logic [18:0] immv);
        return {op, ra, rb, immv};
    endfunction

    function automatic word_t encBr(regIdx_t ra, logic [1:0] cond, logic [18:0] immv);
        return {opBr, ra, 2'b00, cond, immv};
    endfunction

    task automatic setReg(input regIdx_t r, input word_t v);
        // R0 stays zero
        if (r != 4'd0) begin
            modelReg[r] = v;
        end
    endtask

    // Instruction-level model, registers start cleared as on run
    task automatic runModel(output logic done);
        word_t   pc;
        word_t   ins;
        word_t   immv;
        word_t   va;
        word_t   ea;
        regIdx_t ra;
        regIdx_t rb;
        regIdx_t rc;
        logic    taken;
        int      steps;
        for (int i = 0; i < 16; i++) begin
            modelReg[i] = '0;
        end
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 200) begin
            ins  = modelMem[pc[7:0]];
            pc   = pc + 32'd1;
            ra   = ins[26:23];
            rb   = ins[22:19];
            rc   = ins[18:15];
            immv = {{13{ins[18]}}, ins[18:0]};
            ea   = modelReg[rb] + immv;
            steps++;
            case (ins[31:27])
                opAdd:  setReg(ra, modelReg[rb] + modelReg[rc]);
                opSub:  setReg(ra, modelReg[rb] - modelReg[rc]);
                opAnd:  setReg(ra, modelReg[rb] & modelReg[rc]);
                opOr:   setReg(ra, modelReg[rb] | modelReg[rc]);
                opAddi: setReg(ra, modelReg[rb] + immv);
                opAndi: setReg(ra, modelReg[rb] & immv);
                opOri:  setReg(ra, modelReg[rb] | immv);
                opLd:   setReg(ra, modelMem[ea[7:0]]);
                opSt:   modelMem[ea[7:0]] = modelReg[ra];
                opBr: begin
                    va = modelReg[ra];
                    case (ins[20:19])
                        brZero:    taken = (va == '0);
                        brNonZero: taken = (va != '0);
                        brPos:     taken = !va[31] && (va != '0);
                        default:   taken = va[31];
                    endcase
                    // Target relative to the already stepped PC
                    if (taken) begin
                        pc = pc + immv;
                    end
                end
                opHlt:   done = 1'b1;
                default: ;
            endcase
        end
    endtask

    // Random body, one forward branch, store epilogue, HLT
    task automatic genProgram(output int progLen);
        int          n;
        int          bp;
        int          skip;
        int          kind;
        regIdx_t     ra;
        regIdx_t     rb;
        regIdx_t     rc;
        logic [18:0] immv;
        logic [18:0] dataImm;
        n    = int'($urandom_range(40, 20));
        skip = int'($urandom_range(4, 1));
        // Target lands at most on the first epilogue word
        bp   = int'($urandom_range(n - skip - 1, 0));
        for (int i = 0; i < n; i++) begin
            ra      = 4'($urandom_range(15));
            rb      = 4'($urandom_range(15));
            rc      = 4'($urandom_range(15));
            immv    = 19'($urandom);
            dataImm = 19'(128 + int'($urandom_range(63)));
            kind    = int'($urandom_range(10));
            if (i == bp) begin
                modelMem[i] = encBr(ra, 2'($urandom_range(3)), 19'(skip));
            end else begin
                case (kind)
                    0:       modelMem[i] = encReg(opAdd, ra, rb, rc);
                    1:       modelMem[i] = encReg(opSub, ra, rb, rc);
                    2:       modelMem[i] = encReg(opAnd, ra, rb, rc);
                    3:       modelMem[i] = encReg(opOr, ra, rb, rc);
                    4, 5:    modelMem[i] = encImm(opAddi, ra, rb, immv);
                    6:       modelMem[i] = encImm(opAndi, ra, rb, immv);
                    7:       modelMem[i] = encImm(opOri, ra, rb, immv);
                    // Loads and stores base on R0, data words only
                    8:       modelMem[i] = encImm(opLd, ra, 4'd0, dataImm);
                    9:       modelMem[i] = encImm(opSt, ra, 4'd0, dataImm);
                    default: modelMem[i] = {opNop, 27'd0};
                endcase
            end
        end
        // R1..R15 to words 240..254
        for (int r = 1; r < 16; r++) begin
            modelMem[n + r - 1] = encImm(opSt, 4'(r), 4'd0, 19'(239 + r));
        end
        modelMem[n + 15] = {opHlt, 27'd0};
        progLen = n + 16;
        // NOP filler tagged with its own address
        for (int i = progLen; i < `MEM_WORDS; i++) begin
            modelMem[i] = {opNop, 19'd0, 8'(i)};
        end
        for (int i = 128; i < 192; i++) begin
            modelMem[i] = $urandom;
        end
        for (int i = 240; i < 255; i++) begin
            modelMem[i] = $urandom;
        end
    endtask

    // Host writes to random words, then reads each back
    task automatic apbRoundTrip();
        int    errBefore;
        int    idx;
        word_t data;
        word_t rd;
        errBefore = errCount;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            written[i] = 1'b0;
        end
        for (int n = 0; n < 48; n++) begin
            idx  = int'($urandom_range(`MEM_WORDS - 1));
            data = $urandom;
            memWrite(idx, data);
            shadow[idx]  = data;
            written[idx] = 1'b1;
        end
        for (int i = 0; i < `MEM_WORDS; i++) begin
            if (written[i]) begin
                memRead(i, rd);
                if (rd !== shadow[i]) begin
                    reportMismatch($sformatf("mem[%0d]", i), shadow[i], rd);
                end
            end
        end
        logResult("apb round trip", errBefore);
    endtask

    // Unmapped addresses just above memory and next to the control word
    task automatic unmappedAccess();
        int    errBefore;
        int    idx;
        word_t addr;
        word_t rd;
        logic  err;
        errBefore = errCount;
        for (int n = 0; n < 8; n++) begin
            if (n % 3 == 2) begin
                addr = `CTRL_ADDR + 32'd4;
            end else begin
                // Aliases onto a written word if decode were partial
                idx = int'($urandom_range(`MEM_WORDS - 1));
                while (!written[idx]) begin
                    idx = int'($urandom_range(`MEM_WORDS - 1));
                end
                addr = 32'h0000_0400 + word_t'(4 * idx);
            end
            apbXfer(addr, n[0], $urandom, rd, err);
            if (!err) begin
                $display("No pslverr for an access to unmapped address %h at %0t", addr, $time);
                errCount++;
            end
        end
        // Memory untouched
        for (int i = 0; i < `MEM_WORDS; i++) begin
            if (written[i]) begin
                memRead(i, rd);
                if (rd !== shadow[i]) begin
                    reportMismatch($sformatf("mem[%0d]", i), shadow[i], rd);
                end
            end
        end
        logResult("apb error response", errBefore);
    endtask

    task automatic controlRegister();
        int    errBefore;
        word_t status;
        errBefore = errCount;
        ctrlRead(status);
        if (status !== 32'h0) begin
            reportMismatch("prdata", 32'h0, status);
        end
        memWrite(0, {opHlt, 27'd0});
        ctrlWrite(32'h1);
        waitHalted(status);
        if (status !== 32'h2) begin
            reportMismatch("prdata", 32'h2, status);
        end
        // BR zero on R0 back onto itself keeps the core busy
        memWrite(0, encBr(4'd0, 2'b00, 19'h7ffff));
        ctrlWrite(32'h1);
        ctrlRead(status);
        if (status !== 32'h0) begin
            reportMismatch("prdata", 32'h0, status);
        end
        // Patch the loop into a HLT while it spins
        memWrite(0, {opHlt, 27'd0});
        waitHalted(status);
        if (status !== 32'h2) begin
            reportMismatch("prdata", 32'h2, status);
        end
        logResult("control register", errBefore);
    endtask

    task automatic runProgram(input string name, input logic contend);
        int    errBefore;
        int    progLen;
        int    idx;
        logic  done;
        word_t rd;
        word_t status;
        errBefore = errCount;
        genProgram(progLen);
        for (int i = 0; i < 192; i++) begin
            memWrite(i, modelMem[i]);
        end
        for (int i = 240; i < 255; i++) begin
            memWrite(i, modelMem[i]);
        end
        // Words 0..127 are never stored to, so the image survives in the model
        runModel(done);
        if (!done) begin
            $display("%s: reference model did not reach HLT", name);
            errCount++;
        end
        ctrlWrite(32'h1);
        status = '0;
        while (!status[1]) begin
            if (contend) begin
                repeat (3) begin
                    idx = int'($urandom_range(127));
                    memRead(idx, rd);
                    if (rd !== modelMem[idx]) begin
                        reportMismatch($sformatf("mem[%0d]", idx), modelMem[idx], rd);
                    end
                end
            end
            ctrlRead(status);
        end
        // Data region and register dump
        for (int i = 128; i < 192; i++) begin
            memRead(i, rd);
            if (rd !== modelMem[i]) begin
                reportMismatch($sformatf("mem[%0d]", i), modelMem[i], rd);
            end
        end
        for (int i = 240; i < 255; i++) begin
            memRead(i, rd);
            if (rd !== modelMem[i]) begin
                reportMismatch($sformatf("mem[%0d]", i), modelMem[i], rd);
            end
        end
        logResult($sformatf("%s (%0d words)", name, progLen), errBefore);
    endtask

    initial begin
        nRst        = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        errCount    = 0;
        testsPassed = 0;
        testsFailed = 0;
        void'($urandom(32'hb1ba));
        repeat (10) @(posedge iClk);
        #1;
        nRst = 1'b1;

        apbRoundTrip();
        unmappedAccess();
        controlRegister();
        for (int p = 0; p < NUM_PROGS - 1; p++) begin
            runProgram($sformatf("random program %0d", p), 1'b0);
        end
        runProgram("program under host reads", 1'b1);

        $display("Summary: %0d passed, %0d failed", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== miniCpuTop.f ====
+incdir+hdl
hdl/miniPkg.sv
hdl/controlUnit.sv
hdl/dataPath.sv
hdl/busArbiter.sv
hdl/sharedMem.sv
hdl/miniCpuTop.sv
sim/miniCpuTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f miniCpuTop.f --top-module miniCpuTb -o miniCpuTb
	./obj_dir/miniCpuTb | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
